//--- verilog/proc_defines.svh
// Datapath, register index and memory address width macros
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// Datapath and register file
`define DATA_W 16
`define REG_AW 3

// Internal memories, word addressed
`define IMEM_AW 8
`define DMEM_AW 8

`endif

//--- verilog/isaPkg.sv
// Opcode enum, instruction field struct and immediate extraction
`include "proc_defines.svh"

package isaPkg;

    typedef enum logic [4:0] {
        opNop  = 5'h00,
        opHalt = 5'h01,
        opAdd  = 5'h02,
        opSub  = 5'h03,
        opAnd  = 5'h04,
        opXor  = 5'h05,
        opAddi = 5'h06,
        opLd   = 5'h07,
        opSt   = 5'h08,
        opBeqz = 5'h09,
        opBnez = 5'h0a
    } opcodeT;

    // Raw opcode bits, so illegal codes stay visible
    typedef struct packed {
        logic [4:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [1:0]         lowBits;
    } instrT;

    // ADDI, LD and ST offset
    function automatic logic [`DATA_W-1:0] imm5(input instrT instr);
        logic [4:0] raw;
        raw = {instr.rd, instr.lowBits};
        return {{(`DATA_W - 5){raw[4]}}, raw};
    endfunction

    // Branch offset, relative to the branch address plus one
    function automatic logic [`DATA_W-1:0] imm8(input instrT instr);
        logic [7:0] raw;
        raw = {instr.rt, instr.rd, instr.lowBits};
        return {{(`DATA_W - 8){raw[7]}}, raw};
    endfunction

endpackage

//--- verilog/pipePkg.sv
// Pipeline register structs handed between stages, and the writeback trace
`include "proc_defines.svh"

package pipePkg;

    // Fetch to decode
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
        isaPkg::instrT      instr;
    } ifIdT;

    // Decode to execute
    typedef struct packed {
        logic               valid;
        isaPkg::opcodeT     op;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] rsVal;
        logic [`DATA_W-1:0] rtVal;
        logic [`DATA_W-1:0] imm;
        logic [`REG_AW-1:0] dest;
        logic               regWrite;
    } idExT;

    // Execute to memory
    typedef struct packed {
        logic               valid;
        isaPkg::opcodeT     op;
        logic [`DATA_W-1:0] result;
        logic [`DATA_W-1:0] storeData;
        logic [`REG_AW-1:0] dest;
        logic               regWrite;
    } exMemT;

    // Register file write, also the trace seen at the top level
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] regIdx;
        logic [`DATA_W-1:0] data;
    } wbT;

endpackage

//--- verilog/fetch.sv
// Fetch stage: program counter, instruction memory with load port, fetch-to-decode register
`timescale 1ns/1ps
`default_nettype none
`include "proc_defines.svh"

module fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                imemWe,
    input  logic [`IMEM_AW-1:0] imemAddr,
    input  logic [`DATA_W-1:0]  imemData,
    input  logic                stall,
    input  logic                flush,
    input  logic [`DATA_W-1:0]  branchTarget,
    input  logic                halted,
    output pipePkg::ifIdT       ifId,
    output logic                err
);
    import isaPkg::*;

    logic [`DATA_W-1:0] imem [0:(1 << `IMEM_AW) - 1];
    logic [`DATA_W-1:0] pc;
    logic               pcInRange;
    instrT              fetchWord;
    logic               haltFetched;

    assign pcInRange = (pc >> `IMEM_AW) == '0;
    assign fetchWord = imem[pc[`IMEM_AW-1:0]];

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            ifId.valid  <= 1'b0;
            haltFetched <= 1'b0;
            err         <= 1'b0;
        end else if (flush) begin
            // Taken branch in execute, drop the instruction being fetched
            pc          <= branchTarget;
            ifId.valid  <= 1'b0;
            haltFetched <= 1'b0;
        end else if (!stall && !halted) begin
            if (haltFetched) begin
                ifId.valid <= 1'b0;
            end else begin
                pc          <= pc + 1'b1;
                ifId.valid  <= pcInRange;
                ifId.pc     <= pc;
                ifId.instr  <= fetchWord;
                // Once a HALT is fetched, nothing past it follows
                haltFetched <= pcInRange && fetchWord.op == opHalt;
                err         <= err | !pcInRange;
            end
        end
    end

    // Program loading only happens while the core is held in reset
    assert property (@(posedge clk) !reset |-> !imemWe)
        else $error("instruction memory written outside reset");

endmodule
`default_nettype wire

//--- verilog/decode.sv
// Decode stage: register file, control decode, hazard stall, decode-to-execute register
`timescale 1ns/1ps
`default_nettype none
`include "proc_defines.svh"

module decode (
    input  logic           clk,
    input  logic           reset,
    input  pipePkg::ifIdT  ifId,
    input  logic           flush,
    input  pipePkg::wbT    wb,
    input  pipePkg::exMemT exMem,
    output pipePkg::idExT  idEx,
    output logic           stall,
    output logic           err
);
    import isaPkg::*;

    logic [`DATA_W-1:0] regs [0:(1 << `REG_AW) - 1];
    instrT              instr;
    logic               usesRs;
    logic               usesRt;
    logic               regWrite;
    logic               illegal;
    logic [`REG_AW-1:0] dest;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] rsVal;
    logic [`DATA_W-1:0] rtVal;
    logic               rsHazard;
    logic               rtHazard;
    logic               issue;

    assign instr = ifId.instr;

    always_comb begin
        usesRs   = 1'b0;
        usesRt   = 1'b0;
        regWrite = 1'b0;
        illegal  = 1'b0;
        dest     = instr.rd;
        imm      = imm5(instr);
        case (instr.op)
            opAdd, opSub, opAnd, opXor: begin
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                regWrite = 1'b1;
            end
            opAddi, opLd: begin
                usesRs   = 1'b1;
                regWrite = 1'b1;
                dest     = instr.rt;
            end
            // rt carries the store data
            opSt: begin
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            opBeqz, opBnez: begin
                usesRs = 1'b1;
                imm    = imm8(instr);
            end
            opNop, opHalt: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    // Same-cycle writeback bypasses the array
    assign rsVal = (wb.valid && wb.regIdx == instr.rs) ? wb.data : regs[instr.rs];
    assign rtVal = (wb.valid && wb.regIdx == instr.rt) ? wb.data : regs[instr.rt];

    // Results still in flight in execute or memory
    assign rsHazard = (idEx.valid && idEx.regWrite && idEx.dest == instr.rs)
                   || (exMem.valid && exMem.regWrite && exMem.dest == instr.rs);
    assign rtHazard = (idEx.valid && idEx.regWrite && idEx.dest == instr.rt)
                   || (exMem.valid && exMem.regWrite && exMem.dest == instr.rt);

    assign stall = ifId.valid && ((usesRs && rsHazard) || (usesRt && rtHazard));
    assign issue = ifId.valid && !stall && !flush && !illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << `REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            err           <= 1'b0;
        end else begin
            idEx.valid    <= issue;
            idEx.regWrite <= issue && regWrite;
            // Sticky until the next reset
            err           <= err | (ifId.valid && illegal && !flush);
        end
        idEx.op    <= opcodeT'(instr.op);
        idEx.pc    <= ifId.pc;
        idEx.rsVal <= rsVal;
        idEx.rtVal <= rtVal;
        idEx.imm   <= imm;
        idEx.dest  <= dest;
    end

    // A stalled instruction waits in the fetch-to-decode register
    assert property (@(posedge clk) disable iff (reset) (stall && !flush) |=> $stable(ifId))
        else $error("fetch moved on while decode stalled");

endmodule
`default_nettype wire

//--- verilog/execute.sv
// Execute stage: ALU, branch resolution and flush, execute-to-memory register
`timescale 1ns/1ps
`default_nettype none
`include "proc_defines.svh"

module execute (
    input  logic               clk,
    input  logic               reset,
    input  pipePkg::idExT      idEx,
    output pipePkg::exMemT     exMem,
    output logic               flush,
    output logic [`DATA_W-1:0] branchTarget
);
    import isaPkg::*;

    logic [`DATA_W-1:0] result;
    logic               rsZero;

    always_comb begin
        case (idEx.op)
            opAdd:   result = idEx.rsVal + idEx.rtVal;
            opSub:   result = idEx.rsVal - idEx.rtVal;
            opAnd:   result = idEx.rsVal & idEx.rtVal;
            opXor:   result = idEx.rsVal ^ idEx.rtVal;
            // ADDI sum, or the LD and ST address
            default: result = idEx.rsVal + idEx.imm;
        endcase
    end

    assign rsZero = idEx.rsVal == '0;

    // Taken branch kills the two younger instructions
    assign flush = idEx.valid
                && ((idEx.op == opBeqz && rsZero) || (idEx.op == opBnez && !rsZero));
    assign branchTarget = idEx.pc + idEx.imm + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid    <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            exMem.valid    <= idEx.valid;
            exMem.regWrite <= idEx.valid && idEx.regWrite;
        end
        exMem.op        <= idEx.op;
        exMem.result    <= result;
        exMem.storeData <= idEx.rtVal;
        exMem.dest      <= idEx.dest;
    end

endmodule
`default_nettype wire

//--- verilog/memory.sv
// Memory stage: data memory, writeback select and trace, halt detection
`timescale 1ns/1ps
`default_nettype none
`include "proc_defines.svh"

module memory (
    input  logic           clk,
    input  logic           reset,
    input  pipePkg::exMemT exMem,
    output pipePkg::wbT    wb,
    output logic           halted,
    output logic           err
);
    import isaPkg::*;

    logic [`DATA_W-1:0]  dmem [0:(1 << `DMEM_AW) - 1];
    logic [`DMEM_AW-1:0] addr;
    logic                live;
    logic                isLoad;
    logic                isStore;
    logic                outOfRange;

    assign addr = exMem.result[`DMEM_AW-1:0];
    // Nothing behind a HALT changes state
    assign live = exMem.valid && !halted;
    assign isLoad = live && exMem.op == opLd;
    assign isStore = live && exMem.op == opSt;
    assign outOfRange = (exMem.result >> `DMEM_AW) != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << `DMEM_AW); i++) begin
                dmem[i] <= '0;
            end
        end else if (isStore && !outOfRange) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
            halted   <= 1'b0;
            err      <= 1'b0;
        end else begin
            wb.valid <= live && exMem.regWrite;
            halted   <= halted | (live && exMem.op == opHalt);
            err      <= err | ((isLoad || isStore) && outOfRange);
        end
        wb.regIdx <= exMem.dest;
        wb.data   <= isLoad ? dmem[addr] : exMem.result;
    end

    // Trace stays quiet once the core has halted
    assert property (@(posedge clk) disable iff (reset) halted |-> !wb.valid)
        else $error("writeback after halt");

endmodule
`default_nettype wire

//--- verilog/proc.sv
// Processor top level: four pipeline stages and the combined error flag
`timescale 1ns/1ps
`default_nettype none
`include "proc_defines.svh"

module proc (
    input  logic                clk,
    input  logic                reset,
    input  logic                imemWe,
    input  logic [`IMEM_AW-1:0] imemAddr,
    input  logic [`DATA_W-1:0]  imemData,
    output pipePkg::wbT         wb,
    output logic                halted,
    output logic                err
);
    import pipePkg::*;

    ifIdT               ifId;
    idExT               idEx;
    exMemT              exMem;
    logic               stall;
    logic               flush;
    logic [`DATA_W-1:0] branchTarget;
    logic               fetchErr;
    logic               decodeErr;
    logic               memErr;

    fetch fetch0 (
        .clk          (clk),
        .reset        (reset),
        .imemWe       (imemWe),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .stall        (stall),
        .flush        (flush),
        .branchTarget (branchTarget),
        .halted       (halted),
        .ifId         (ifId),
        .err          (fetchErr)
    );

    decode decode0 (
        .clk   (clk),
        .reset (reset),
        .ifId  (ifId),
        .flush (flush),
        .wb    (wb),
        .exMem (exMem),
        .idEx  (idEx),
        .stall (stall),
        .err   (decodeErr)
    );

    execute execute0 (
        .clk          (clk),
        .reset        (reset),
        .idEx         (idEx),
        .exMem        (exMem),
        .flush        (flush),
        .branchTarget (branchTarget)
    );

    memory memory0 (
        .clk    (clk),
        .reset  (reset),
        .exMem  (exMem),
        .wb     (wb),
        .halted (halted),
        .err    (memErr)
    );

    assign err = fetchErr | decodeErr | memErr;

endmodule
`default_nettype wire

//--- test/procChecker.sv
// Trace checker: compares the writeback trace, halted and err with the expected values
`timescale 1ns/1ps
`include "proc_defines.svh"

module procChecker #(
    parameter int MAX_TRACE = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  pipePkg::wbT wb,
    input  logic        halted,
    input  logic        err,
    input  logic [3:0]  testNum,
    input  int          expCount,
    input  logic        expErr,
    input  pipePkg::wbT expTrace [0:MAX_TRACE-1],
    input  logic        testDone,
    output int          mismatches,
    output int          missing,
    output int          extras,
    output int          flagErrors
);
    import pipePkg::*;

    // Trace entries seen in the current test
    int seen;

    function automatic string testName();
        return $sformatf("test%0d", testNum);
    endfunction

    initial begin
        mismatches = 0;
        missing    = 0;
        extras     = 0;
        flagErrors = 0;
        seen       = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            seen = 0;
        end else begin
            if (wb.valid === 1'b1) begin
                if (seen >= expCount) begin
                    $display("%s wrote back an unexpected extra entry r%0d = %h",
                             testName(), wb.regIdx, wb.data);
                    extras++;
                end else if (wb.regIdx !== expTrace[seen].regIdx
                          || wb.data !== expTrace[seen].data) begin
                    $display("ERR %s entry %0d: expected r%0d = %h, actual r%0d = %h",
                             testName(), seen, expTrace[seen].regIdx, expTrace[seen].data,
                             wb.regIdx, wb.data);
                    mismatches++;
                end
                seen++;
            end
            // End of test, the trace must be complete and the flags settled
            if (testDone) begin
                if (seen < expCount) begin
                    $display("%s ended with %0d of %0d trace entries never written back",
                             testName(), expCount - seen, expCount);
                    missing += expCount - seen;
                end
                if (err !== expErr) begin
                    $display("ERR %s err: expected %0b, actual %0b", testName(), expErr, err);
                    flagErrors++;
                end
                if (halted !== 1'b1) begin
                    $display("ERR %s halted: expected 1, actual %0b", testName(), halted);
                    flagErrors++;
                end
            end
        end
    end

endmodule

//--- test/procTb.sv
// Testbench top: clock, reset, golden file reader, program loader, watchdog and closing report
`timescale 1ns/1ps
`include "proc_defines.svh"

module procTb;
    import pipePkg::*;

    localparam int GOLDEN_WORDS = 256;
    localparam int MAX_TRACE = 32;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_WORD = 40;
    localparam int SETTLE_CYCLES = 8;

    logic                clk;
    logic                reset;
    logic                imemWe;
    logic [`IMEM_AW-1:0] imemAddr;
    logic [`DATA_W-1:0]  imemData;
    wbT                  wb;
    logic                halted;
    logic                err;

    logic [`DATA_W-1:0]  golden [0:GOLDEN_WORDS-1];
    logic [3:0]          testNum;
    int                  expCount;
    logic                expErr;
    wbT                  expTrace [0:MAX_TRACE-1];
    logic                testDone;
    int                  mismatches;
    int                  missing;
    int                  extras;
    int                  flagErrors;
    int                  watchdogCycles;
    logic                watchdogArmed;

    proc DUT (
        .clk      (clk),
        .reset    (reset),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wb       (wb),
        .halted   (halted),
        .err      (err)
    );

    procChecker #(.MAX_TRACE(MAX_TRACE)) traceCheck (
        .clk        (clk),
        .reset      (reset),
        .wb         (wb),
        .halted     (halted),
        .err        (err),
        .testNum    (testNum),
        .expCount   (expCount),
        .expErr     (expErr),
        .expTrace   (expTrace),
        .testDone   (testDone),
        .mismatches (mismatches),
        .missing    (missing),
        .extras     (extras),
        .flagErrors (flagErrors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Inputs change 1 ns after the rising edge
    task automatic waitCycle();
        @(posedge clk);
        #1;
    endtask

    // Header word: test[15:12], program length[11:6], trace count[5:1], err[0]
    function automatic bit headerValid(input logic [`DATA_W-1:0] header);
        return !$isunknown(header) && header != '0;
    endfunction

    function automatic int recordLength(input logic [`DATA_W-1:0] header);
        return 1 + int'(header[11:6]) + 2 * int'(header[5:1]);
    endfunction

    // Reset stays high for at least 5 cycles and until the whole program is in
    task automatic loadProgram(input int first, input int len);
        int cycles;
        cycles = (len > RESET_CYCLES) ? len : RESET_CYCLES;
        reset = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            imemWe   = i < len;
            imemAddr = i[`IMEM_AW-1:0];
            imemData = (i < len) ? golden[first + i] : '0;
            waitCycle();
        end
        imemWe = 1'b0;
        reset  = 1'b0;
    endtask

    task automatic runTest(input int base);
        logic [`DATA_W-1:0] header;
        int                 len;
        int                 tracePos;
        header   = golden[base];
        len      = int'(header[11:6]);
        testNum  = header[15:12];
        expCount = int'(header[5:1]);
        expErr   = header[0];
        for (int i = 0; i < MAX_TRACE; i++) begin
            expTrace[i] = '0;
        end
        for (int i = 0; i < expCount; i++) begin
            tracePos = base + 1 + len + 2 * i;
            expTrace[i].valid  = 1'b1;
            expTrace[i].regIdx = golden[tracePos][`REG_AW-1:0];
            expTrace[i].data   = golden[tracePos + 1];
        end
        loadProgram(base + 1, len);
        while (!(expErr ? err : halted)) begin
            waitCycle();
        end
        // Time for writebacks still in flight, and for any stray ones
        repeat (SETTLE_CYCLES) waitCycle();
        testDone = 1'b1;
        waitCycle();
        testDone = 1'b0;
    endtask

    initial begin
        int ptr;
        int total;
        reset         = 1'b1;
        imemWe        = 1'b0;
        imemAddr      = '0;
        imemData      = '0;
        testNum       = '0;
        expCount      = 0;
        expErr        = 1'b0;
        testDone      = 1'b0;
        watchdogArmed = 1'b0;
        for (int i = 0; i < MAX_TRACE; i++) begin
            expTrace[i] = '0;
        end
        $readmemh("test/proc_golden.mem", golden);
        watchdogCycles = 0;
        ptr = 0;
        while (ptr < GOLDEN_WORDS && headerValid(golden[ptr])) begin
            watchdogCycles += CYCLES_PER_WORD * int'(golden[ptr][11:6]);
            ptr += recordLength(golden[ptr]);
        end
        watchdogArmed = 1'b1;
        ptr = 0;
        while (ptr < GOLDEN_WORDS && headerValid(golden[ptr])) begin
            runTest(ptr);
            ptr += recordLength(golden[ptr]);
        end
        waitCycle();
        total = mismatches + missing + extras + flagErrors;
        $display("Error counts: %0d mismatched, %0d missing, %0d extra, %0d flag errors",
                 mismatches, missing, extras, flagErrors);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdogArmed === 1'b1);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- test/proc_golden.mem
// Per test: header (test[15:12] length[11:6] count[5:1] err[0]), program words,
// then the expected trace as register and data pairs. A zero header ends the file
// Test 1, ALU operations
128e
3027 305d 0000 0000 114c 1950 2154 2958 183c 0800
0001 0007 0002 fffd 0003 0004 0004 000a 0005 0005 0006 fffa 0007 fff9
// Test 2, back-to-back dependent chain
21cc
3025 3129 1128 1a2c 2b50 3490 0800
0001 0005 0001 000e 0002 001c 0003 000e 0004 0012 0004 0002
// Test 3, store then load, and a load from an untouched address
320a
302c 3043 4224 3a64 3889 417f 38ab 0800
0001 000c 0002 0003 0003 000c 0004 0000 0005 000c
// Test 4, taken and not-taken BEQZ and BNEZ
4308
3021 4902 3042 5102 3063 3084 4801 30a5 30c6 5001 30e7 0800
0001 0001 0002 0002 0006 0006 0007 0007
// Test 5, nothing after HALT writes back
5102
302a 0800 3041 3062
0001 000a
// Test 6, illegal opcode raises err
6105
3023 f800 3141 0800
0001 0003 0002 0004
// End marker
0000

//--- sim.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/proc.sv
test/procChecker.sv
test/procTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal --top-module procTb -f sim.f -o procSim \
    || exit 1
./obj_dir/procSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
